/* source/bp_pkg.sv */
package bp_pkg;

   localparam int PC_W = 32;               // Program counter width

   typedef logic [PC_W-1:0] pc_t;

   localparam pc_t PC_STEP = pc_t'(4);     // Sequential fetch increment

   // 2-bit saturating direction counter
   typedef enum logic [1:0] {
      STRONG_NT = 2'd0,
      WEAK_NT   = 2'd1,
      WEAK_T    = 2'd2,
      STRONG_T  = 2'd3
   } ctr_t;

   // Upper half of the counter range predicts taken
   function automatic logic ctr_taken(ctr_t ctr);
      return (ctr >= WEAK_T);
   endfunction

   // Move the counter one step toward the resolved outcome
   function automatic ctr_t ctr_update(ctr_t ctr, logic taken);
      ctr_t nxt;
      nxt = ctr;
      if (taken && (ctr != STRONG_T)) begin
         nxt = ctr_t'(ctr + 2'd1);
      end else if (!taken && (ctr != STRONG_NT)) begin
         nxt = ctr_t'(ctr - 2'd1);
      end
      return nxt;
   endfunction

endpackage

/* source/bp_update_if.sv */
`timescale 1ns/100ps

interface bp_update_if
   import bp_pkg::*;
();

   logic upd_valid;                        // Single-cycle resolution strobe
   pc_t  upd_pc;                           // Address of the resolved branch
   logic upd_taken;
   pc_t  upd_target;
   logic upd_mispredict;                   // Fetch went the wrong way

   modport producer (
      output upd_valid,
      output upd_pc,
      output upd_taken,
      output upd_target,
      output upd_mispredict
   );

   modport consumer (
      input upd_valid,
      input upd_pc,
      input upd_taken,
      input upd_target,
      input upd_mispredict
   );

endinterface

/* source/tagged_table.sv */
`timescale 1ns/100ps

module tagged_table #(
   parameter type entry_t = logic [7:0],
   parameter int  IDX_W   = 5
) (
   input  logic             clk_i,
   input  logic             rstn_i,

   // Lookup port for the fetch side
   input  logic [IDX_W-1:0] rd_idx_i,
   output entry_t           rd_entry_o,

   // Read port for the read-modify-write of the update side
   input  logic [IDX_W-1:0] upd_rd_idx_i,
   output entry_t           upd_rd_entry_o,

   input  logic             wr_en_i,
   input  logic [IDX_W-1:0] wr_idx_i,
   input  entry_t           wr_entry_i
);

   localparam int DEPTH = 2 ** IDX_W;

   entry_t mem_q [DEPTH];                  // Flop array with combinational reads

   // All entries start invalid so nothing hits right after reset
   always_ff @(posedge clk_i) begin
      if (!rstn_i) begin
         for (int i = 0; i < DEPTH; i++) begin
            mem_q[i] <= '0;
         end
      end else if (wr_en_i) begin
         mem_q[wr_idx_i] <= wr_entry_i;    // Visible to lookups from next cycle
      end
   end

   assign rd_entry_o     = mem_q[rd_idx_i];
   assign upd_rd_entry_o = mem_q[upd_rd_idx_i];

endmodule

/* source/branch_predictor.sv */
`timescale 1ns/100ps

module branch_predictor
   import bp_pkg::*;
#(
   parameter int BTB_IDX_W = 5,
   parameter int BHT_IDX_W = 5
) (
   input  logic          clk_i,
   input  logic          rstn_i,

   input  pc_t           pc_i,             // Current fetch address
   bp_update_if.consumer upd,

   output logic          pred_taken_o,
   output pc_t           pred_target_o,
   output logic [31:0]   correct_count_o,
   output logic [31:0]   wrong_count_o
);

   localparam int BTB_TAG_W = PC_W - BTB_IDX_W;
   localparam int BHT_TAG_W = PC_W - BHT_IDX_W;

   typedef struct packed {
      logic                 valid;
      logic [BTB_TAG_W-1:0] tag;
      pc_t                  target;
   } btb_entry_t;

   typedef struct packed {
      logic [BHT_TAG_W-1:0] tag;
      ctr_t                 ctr;
   } bht_entry_t;

   logic [BHT_IDX_W-1:0] ghr_q;            // Global history with the newest outcome in bit 0
   logic [31:0]          correct_q;
   logic [31:0]          wrong_q;

   logic [BTB_IDX_W-1:0] btb_rd_idx;
   logic [BTB_IDX_W-1:0] btb_upd_idx;
   logic [BHT_IDX_W-1:0] bht_rd_idx;
   logic [BHT_IDX_W-1:0] bht_upd_idx;

   btb_entry_t           btb_rd_entry;
   btb_entry_t           btb_upd_entry;
   btb_entry_t           btb_wr_entry;
   bht_entry_t           bht_rd_entry;
   bht_entry_t           bht_upd_entry;
   bht_entry_t           bht_wr_entry;

   logic                 btb_wr_en;
   logic                 btb_hit;
   logic                 bht_hit;

   // gshare index from the low PC bits folded with the history
   assign btb_rd_idx  = pc_i[BTB_IDX_W-1:0];
   assign bht_rd_idx  = pc_i[BHT_IDX_W-1:0] ^ ghr_q;
   assign btb_upd_idx = upd.upd_pc[BTB_IDX_W-1:0];
   assign bht_upd_idx = upd.upd_pc[BHT_IDX_W-1:0] ^ ghr_q;

   tagged_table #(
      .entry_t (btb_entry_t),
      .IDX_W   (BTB_IDX_W)
   ) u_btb (
      .clk_i          (clk_i),
      .rstn_i         (rstn_i),
      .rd_idx_i       (btb_rd_idx),
      .rd_entry_o     (btb_rd_entry),
      .upd_rd_idx_i   (btb_upd_idx),
      .upd_rd_entry_o (btb_upd_entry),
      .wr_en_i        (btb_wr_en),
      .wr_idx_i       (btb_upd_idx),
      .wr_entry_i     (btb_wr_entry)
   );

   tagged_table #(
      .entry_t (bht_entry_t),
      .IDX_W   (BHT_IDX_W)
   ) u_bht (
      .clk_i          (clk_i),
      .rstn_i         (rstn_i),
      .rd_idx_i       (bht_rd_idx),
      .rd_entry_o     (bht_rd_entry),
      .upd_rd_idx_i   (bht_upd_idx),
      .upd_rd_entry_o (bht_upd_entry),
      .wr_en_i        (upd.upd_valid),     // Every resolved branch trains the BHT
      .wr_idx_i       (bht_upd_idx),
      .wr_entry_i     (bht_wr_entry)
   );

   // Lookup side
   assign btb_hit = btb_rd_entry.valid && (btb_rd_entry.tag == pc_i[PC_W-1:BTB_IDX_W]);
   assign bht_hit = (bht_rd_entry.tag == pc_i[PC_W-1:BHT_IDX_W]);

   assign pred_taken_o  = btb_hit && bht_hit && ctr_taken(bht_rd_entry.ctr)
                          && (btb_rd_entry.target != '0);
   assign pred_target_o = btb_rd_entry.target;

   // The BTB only learns taken branches on the update side
   assign btb_wr_entry = '{
      valid:  1'b1,
      tag:    upd.upd_pc[PC_W-1:BTB_IDX_W],
      target: upd.upd_target
   };
   assign btb_wr_en = upd.upd_valid && upd.upd_taken
                      && (btb_upd_entry != btb_wr_entry); // Skip rewrites of the same entry

   assign bht_wr_entry = '{
      tag: upd.upd_pc[PC_W-1:BHT_IDX_W],
      ctr: ctr_update(bht_upd_entry.ctr, upd.upd_taken)
   };

   always_ff @(posedge clk_i) begin
      if (!rstn_i) begin
         ghr_q     <= '0;
         correct_q <= '0;
         wrong_q   <= '0;
      end else if (upd.upd_valid) begin
         ghr_q <= {ghr_q[BHT_IDX_W-2:0], upd.upd_taken};
         if (upd.upd_mispredict) begin
            wrong_q <= wrong_q + 32'd1;
         end else begin
            correct_q <= correct_q + 32'd1;
         end
      end
   end

   assign correct_count_o = correct_q;
   assign wrong_count_o   = wrong_q;

endmodule

/* source/fetch_pc_gen.sv */
`timescale 1ns/100ps

module fetch_pc_gen
   import bp_pkg::*;
#(
   parameter pc_t RESET_PC = '0
) (
   input  logic          clk_i,
   input  logic          rstn_i,

   input  logic          fetch_stall_i,
   input  logic          pred_taken_i,
   input  pc_t           pred_target_i,
   bp_update_if.consumer upd,

   output pc_t           fetch_pc_o,
   output logic          fetch_valid_o
);

   pc_t  pc_q;
   pc_t  pc_d;
   pc_t  redirect_pc;
   logic valid_q;
   logic hold;

   // Correct path of a mispredicted branch
   assign redirect_pc = upd.upd_taken ? upd.upd_target : (upd.upd_pc + PC_STEP);

   // RESET_PC is presented once as valid before the PC moves on
   assign hold = fetch_stall_i || !valid_q;

   always_comb begin
      if (upd.upd_valid && upd.upd_mispredict) begin
         pc_d = redirect_pc;               // Redirect wins over a stall
      end else if (hold) begin
         pc_d = pc_q;
      end else if (pred_taken_i) begin
         pc_d = pred_target_i;
      end else begin
         pc_d = pc_q + PC_STEP;
      end
   end

   always_ff @(posedge clk_i) begin
      if (!rstn_i) begin
         pc_q    <= RESET_PC;
         valid_q <= 1'b0;
      end else begin
         pc_q    <= pc_d;
         valid_q <= 1'b1;
      end
   end

   assign fetch_pc_o    = pc_q;
   assign fetch_valid_o = valid_q;

endmodule

/* source/fetch_predict_top.sv */
`timescale 1ns/100ps

module fetch_predict_top
   import bp_pkg::*;
#(
   parameter int  BTB_IDX_W = 5,
   parameter int  BHT_IDX_W = 5,
   parameter pc_t RESET_PC  = '0
) (
   input  logic        clk_i,
   input  logic        rstn_i,

   input  logic        fetch_stall_i,

   // Branch resolution from execute
   input  logic        upd_valid_i,
   input  pc_t         upd_pc_i,
   input  logic        upd_taken_i,
   input  pc_t         upd_target_i,
   input  logic        upd_mispredict_i,

   output pc_t         fetch_pc_o,
   output logic        fetch_valid_o,
   output logic        pred_taken_o,
   output pc_t         pred_target_o,
   output logic [31:0] correct_count_o,
   output logic [31:0] wrong_count_o
);

   bp_update_if u_upd ();

   assign u_upd.upd_valid      = upd_valid_i;
   assign u_upd.upd_pc         = upd_pc_i;
   assign u_upd.upd_taken      = upd_taken_i;
   assign u_upd.upd_target     = upd_target_i;
   assign u_upd.upd_mispredict = upd_mispredict_i;

   branch_predictor #(
      .BTB_IDX_W (BTB_IDX_W),
      .BHT_IDX_W (BHT_IDX_W)
   ) u_branch_predictor (
      .clk_i           (clk_i),
      .rstn_i          (rstn_i),
      .pc_i            (fetch_pc_o),       // Predicts for the address being fetched
      .upd             (u_upd.consumer),
      .pred_taken_o    (pred_taken_o),
      .pred_target_o   (pred_target_o),
      .correct_count_o (correct_count_o),
      .wrong_count_o   (wrong_count_o)
   );

   fetch_pc_gen #(
      .RESET_PC (RESET_PC)
   ) u_fetch_pc_gen (
      .clk_i         (clk_i),
      .rstn_i        (rstn_i),
      .fetch_stall_i (fetch_stall_i),
      .pred_taken_i  (pred_taken_o),
      .pred_target_i (pred_target_o),
      .upd           (u_upd.consumer),
      .fetch_pc_o    (fetch_pc_o),
      .fetch_valid_o (fetch_valid_o)
   );

endmodule

/* test/fetch_predict_chk.sv */
`timescale 1ns/100ps

module fetch_predict_chk
   import bp_pkg::*;
(
   input logic        clk_i,
   input logic        rstn_i,
   input logic        fetch_stall_i,
   input logic        upd_valid_i,
   input logic        upd_mispredict_i,
   input pc_t         fetch_pc_o,
   input logic        fetch_valid_o,
   input logic        pred_taken_o,
   input pc_t         pred_target_o,
   input logic [31:0] wrong_count_o
);

   // Valid from the second cycle out of reset
   valid_after_reset: assert property (@(posedge clk_i)
      rstn_i && $past(rstn_i) |-> fetch_valid_o)
      else $error("fetch_valid_o is low after reset");

   stall_holds_pc: assert property (@(posedge clk_i) disable iff (!rstn_i)
      fetch_stall_i && !(upd_valid_i && upd_mispredict_i) |=> $stable(fetch_pc_o))
      else $error("fetch PC moved during a stall without a redirect");

   taken_has_target: assert property (@(posedge clk_i) disable iff (!rstn_i)
      pred_taken_o |-> (pred_target_o != '0))
      else $error("taken prediction with a zero target");

   wrong_count_steps: assert property (@(posedge clk_i) disable iff (!rstn_i)
      upd_valid_i && upd_mispredict_i |=> (wrong_count_o == $past(wrong_count_o) + 32'd1))
      else $error("wrong counter did not rise by one after a mispredict");

endmodule

bind fetch_predict_top fetch_predict_chk u_fetch_predict_chk (
   .clk_i            (clk_i),
   .rstn_i           (rstn_i),
   .fetch_stall_i    (fetch_stall_i),
   .upd_valid_i      (upd_valid_i),
   .upd_mispredict_i (upd_mispredict_i),
   .fetch_pc_o       (fetch_pc_o),
   .fetch_valid_o    (fetch_valid_o),
   .pred_taken_o     (pred_taken_o),
   .pred_target_o    (pred_target_o),
   .wrong_count_o    (wrong_count_o)
);

/* test/fetch_predict_tb.sv */
`timescale 1ns/100ps

module fetch_predict_tb
   import bp_pkg::*;
();

   localparam int  BTB_IDX_W = 5;
   localparam int  BHT_IDX_W = 5;
   localparam pc_t RESET_PC  = 32'h0000_0000;
   localparam pc_t TRAIN_PC  = 32'h0000_0100;     // Branch address used for training
   localparam pc_t TRAIN_TGT = 32'h0000_0400;

   logic        clk_i = 1'b0;
   logic        rstn_i;
   logic        fetch_stall_i;
   logic        upd_valid_i;
   pc_t         upd_pc_i;
   logic        upd_taken_i;
   pc_t         upd_target_i;
   logic        upd_mispredict_i;
   pc_t         fetch_pc_o;
   logic        fetch_valid_o;
   logic        pred_taken_o;
   pc_t         pred_target_o;
   logic [31:0] correct_count_o;
   logic [31:0] wrong_count_o;

   // Reference model of the tables, history and fetch PC
   logic                      m_btb_valid  [2**BTB_IDX_W];
   logic [PC_W-BTB_IDX_W-1:0] m_btb_tag    [2**BTB_IDX_W];
   pc_t                       m_btb_target [2**BTB_IDX_W];
   logic [PC_W-BHT_IDX_W-1:0] m_bht_tag    [2**BHT_IDX_W];
   logic [1:0]                m_bht_ctr    [2**BHT_IDX_W];
   logic [BHT_IDX_W-1:0]      m_ghr;
   pc_t                       m_pc;
   logic                      m_valid;

   int     sent_ok     = 0;                       // Updates issued without mispredict
   int     sent_bad    = 0;
   int     err_count   = 0;
   int     check_count = 0;
   logic   timed_out   = 1'b0;
   integer seed        = 32'hc716abc5;

   always #4 clk_i = ~clk_i;

   fetch_predict_top #(
      .BTB_IDX_W (BTB_IDX_W),
      .BHT_IDX_W (BHT_IDX_W),
      .RESET_PC  (RESET_PC)
   ) u_fetch_predict_top (
      .clk_i            (clk_i),
      .rstn_i           (rstn_i),
      .fetch_stall_i    (fetch_stall_i),
      .upd_valid_i      (upd_valid_i),
      .upd_pc_i         (upd_pc_i),
      .upd_taken_i      (upd_taken_i),
      .upd_target_i     (upd_target_i),
      .upd_mispredict_i (upd_mispredict_i),
      .fetch_pc_o       (fetch_pc_o),
      .fetch_valid_o    (fetch_valid_o),
      .pred_taken_o     (pred_taken_o),
      .pred_target_o    (pred_target_o),
      .correct_count_o  (correct_count_o),
      .wrong_count_o    (wrong_count_o)
   );

   function automatic logic [1:0] next_counter(logic [1:0] ctr, logic taken);
      if (taken) begin
         return (ctr == 2'd3) ? ctr : ctr + 2'd1;
      end
      return (ctr == 2'd0) ? ctr : ctr - 2'd1;
   endfunction

   function automatic logic model_pred_taken(pc_t pc);
      logic [BTB_IDX_W-1:0] bi;
      logic [BHT_IDX_W-1:0] hi;
      bi = pc[BTB_IDX_W-1:0];
      hi = pc[BHT_IDX_W-1:0] ^ m_ghr;             // gshare index
      return m_btb_valid[bi] && (m_btb_tag[bi] == pc[PC_W-1:BTB_IDX_W])
             && (m_bht_tag[hi] == pc[PC_W-1:BHT_IDX_W]) && (m_bht_ctr[hi] >= WEAK_T)
             && (m_btb_target[bi] != '0);
   endfunction

   task automatic model_reset();
      for (int i = 0; i < 2**BTB_IDX_W; i++) begin
         m_btb_valid[i]  = 1'b0;
         m_btb_tag[i]    = '0;
         m_btb_target[i] = '0;
      end
      for (int i = 0; i < 2**BHT_IDX_W; i++) begin
         m_bht_tag[i] = '0;
         m_bht_ctr[i] = 2'd0;
      end
      m_ghr   = '0;
      m_pc    = RESET_PC;
      m_valid = 1'b0;
   endtask

   task automatic model_step(input logic stall, input logic uv, input pc_t upc,
                             input logic taken, input pc_t tgt, input logic misp);
      logic [BHT_IDX_W-1:0] hi;
      logic [BTB_IDX_W-1:0] bi;
      pc_t                  nxt;
      if (uv && misp) begin
         nxt = taken ? tgt : upc + PC_STEP;      // Redirect beats the stall
      end else if (stall || !m_valid) begin
         nxt = m_pc;
      end else if (model_pred_taken(m_pc)) begin
         nxt = m_btb_target[m_pc[BTB_IDX_W-1:0]];
      end else begin
         nxt = m_pc + PC_STEP;
      end
      if (uv) begin
         hi = upc[BHT_IDX_W-1:0] ^ m_ghr;
         bi = upc[BTB_IDX_W-1:0];
         m_bht_tag[hi] = upc[PC_W-1:BHT_IDX_W];
         m_bht_ctr[hi] = next_counter(m_bht_ctr[hi], taken);
         if (taken) begin
            m_btb_valid[bi]  = 1'b1;
            m_btb_tag[bi]    = upc[PC_W-1:BTB_IDX_W];
            m_btb_target[bi] = tgt;
         end
         m_ghr = {m_ghr[BHT_IDX_W-2:0], taken};
      end
      m_pc    = nxt;
      m_valid = 1'b1;
   endtask

   task automatic compare_value(input string what, input logic [31:0] got,
                                input logic [31:0] exp);
      check_count++;
      assert (got === exp) else begin
         err_count++;
         $display("FAIL %0t: %s is 0x%08h, expected 0x%08h", $time, what, got, exp);
      end
   endtask

   task automatic compare_outputs();
      compare_value("fetch_pc_o", fetch_pc_o, m_pc);
      compare_value("fetch_valid_o", 32'(fetch_valid_o), 32'(m_valid));
      compare_value("pred_taken_o", 32'(pred_taken_o), 32'(model_pred_taken(m_pc)));
      if (model_pred_taken(m_pc)) begin
         compare_value("pred_target_o", pred_target_o, m_btb_target[m_pc[BTB_IDX_W-1:0]]);
      end
      compare_value("correct_count_o", correct_count_o, sent_ok);
      compare_value("wrong_count_o", wrong_count_o, sent_bad);
   endtask

   // Drive on the falling edge and check at the next falling edge
   task automatic drive_cycle(input logic stall, input logic uv, input pc_t upc,
                              input logic taken, input pc_t tgt, input logic misp);
      fetch_stall_i    = stall;
      upd_valid_i      = uv;
      upd_pc_i         = upc;
      upd_taken_i      = taken;
      upd_target_i     = tgt;
      upd_mispredict_i = misp;
      if (uv && misp) begin
         sent_bad++;
      end else if (uv) begin
         sent_ok++;
      end
      model_step(stall, uv, upc, taken, tgt, misp);
      @(posedge clk_i);
      @(negedge clk_i);
      compare_outputs();
   endtask

   task automatic idle_cycles(input int n, input logic stall);
      repeat (n) drive_cycle(stall, 1'b0, '0, 1'b0, '0, 1'b0);
   endtask

   task automatic report_test(input string name, input int errs_before);
      $display("test %-14s %0d errors", name, err_count - errs_before);
   endtask

   task automatic apply_reset();
      rstn_i = 1'b0;
      repeat (10) @(posedge clk_i);
      @(negedge clk_i);
      rstn_i = 1'b1;
      model_reset();
   endtask

   task automatic test_reset();
      int  errs;
      int  n;
      errs = err_count;
      compare_outputs();
      n = 0;
      while (!fetch_valid_o && n < 8) begin
         idle_cycles(1, 1'b0);
         n++;
      end
      if (!fetch_valid_o) begin
         $display("Timeout: fetch_valid_o stayed low for 8 cycles after reset");
         timed_out = 1'b1;
      end
      compare_value("PC after reset", fetch_pc_o, RESET_PC);
      for (int i = 0; i < 6; i++) begin
         idle_cycles(1, 1'b0);
         compare_value("sequential PC", fetch_pc_o, RESET_PC + pc_t'(i + 1) * PC_STEP);
         compare_value("pred_taken_o after reset", 32'(pred_taken_o), 32'd0);
      end
      report_test("reset", errs);
   endtask

   task automatic test_training();
      int                   errs;
      int                   n;
      pc_t                  held;
      logic [BHT_IDX_W-1:0] hi;
      errs = err_count;
      held = m_pc;
      for (int i = 0; i < 8; i++) begin
         drive_cycle(1'b1, 1'b1, TRAIN_PC, 1'b1, TRAIN_TGT, 1'b0);
      end
      compare_value("PC held while training", fetch_pc_o, held);
      hi = TRAIN_PC[BHT_IDX_W-1:0] ^ m_ghr;
      compare_value("model counter trained", 32'(m_bht_ctr[hi] >= WEAK_T), 32'd1);
      n = 0;
      while (fetch_pc_o != TRAIN_PC && n < 200) begin
         idle_cycles(1, 1'b0);
         n++;
      end
      if (fetch_pc_o != TRAIN_PC) begin
         $display("Timeout: fetch PC did not reach the trained branch in 200 cycles");
         timed_out = 1'b1;
      end
      compare_value("pred_taken_o at trained PC", 32'(pred_taken_o), 32'd1);
      compare_value("pred_target_o at trained PC", pred_target_o, TRAIN_TGT);
      report_test("training", errs);
   endtask

   task automatic test_pred_redirect();
      int errs;
      errs = err_count;
      idle_cycles(1, 1'b0);
      compare_value("PC after taken prediction", fetch_pc_o, TRAIN_TGT);
      idle_cycles(1, 1'b0);
      compare_value("PC after predicted target", fetch_pc_o, TRAIN_TGT + PC_STEP);
      report_test("pred_redirect", errs);
   endtask

   task automatic test_mispredict();
      int errs;
      errs = err_count;
      drive_cycle(1'b1, 1'b1, 32'h0000_0500, 1'b1, 32'h0000_0800, 1'b1);
      compare_value("PC after taken mispredict", fetch_pc_o, 32'h0000_0800);
      drive_cycle(1'b1, 1'b1, 32'h0000_0840, 1'b0, 32'h0000_0900, 1'b1);
      compare_value("PC after not-taken mispredict", fetch_pc_o, 32'h0000_0844);
      idle_cycles(1, 1'b1);
      compare_value("PC stalled after redirect", fetch_pc_o, 32'h0000_0844);
      report_test("mispredict", errs);
   endtask

   task automatic test_stall();
      int  errs;
      pc_t held;
      errs = err_count;
      held = m_pc;
      for (int i = 0; i < 12; i++) begin
         idle_cycles(1, 1'b1);
         compare_value("PC under stall", fetch_pc_o, held);
      end
      idle_cycles(1, 1'b0);
      report_test("stall", errs);
   endtask

   task automatic test_random();
      int   errs;
      logic stall;
      logic uv;
      logic taken;
      logic misp;
      pc_t  upc;
      pc_t  tgt;
      errs = err_count;
      for (int i = 0; i < 96; i++) begin
         stall = ($random(seed) & 3) == 0;
         uv    = ($random(seed) & 1) != 0;
         upc   = pc_t'($random(seed)) & 32'h0000_007c;   // Small range so tags collide
         taken = ($random(seed) & 1) != 0;
         tgt   = pc_t'($random(seed)) & 32'h0000_03fc;
         // Flag a mispredict where the model would have gone the wrong way
         misp  = (model_pred_taken(upc) != taken)
                 || (taken && (m_btb_target[upc[BTB_IDX_W-1:0]] != tgt));
         drive_cycle(stall, uv, upc, taken, tgt, misp);
      end
      idle_cycles(1, 1'b0);
      compare_value("final correct_count_o", correct_count_o, sent_ok);
      compare_value("final wrong_count_o", wrong_count_o, sent_bad);
      report_test("random", errs);
   endtask

   initial begin
      rstn_i           = 1'b0;
      fetch_stall_i    = 1'b0;
      upd_valid_i      = 1'b0;
      upd_pc_i         = '0;
      upd_taken_i      = 1'b0;
      upd_target_i     = '0;
      upd_mispredict_i = 1'b0;
      apply_reset();
      test_reset();
      if (!timed_out) begin
         test_training();
      end
      if (!timed_out) begin
         test_pred_redirect();
         test_mispredict();
         test_stall();
         test_random();
      end
      $display("checks: %0d, errors: %0d", check_count, err_count);
      if (err_count == 0 && !timed_out) begin
         $display("TB PASSED");
      end else begin
         $display("TB FAILED");
      end
      $finish;
   end

endmodule

/* fetch_predict_top.f */
source/bp_pkg.sv
source/bp_update_if.sv
source/tagged_table.sv
source/branch_predictor.sv
source/fetch_pc_gen.sv
source/fetch_predict_top.sv
test/fetch_predict_chk.sv
test/fetch_predict_tb.sv

/* Makefile */
TOOL     ?= verilator
FLAGS    ?= --binary --timing --assert -j 0
TOP      ?= fetch_predict_tb
FILELIST ?= fetch_predict_top.f
OBJ_DIR  ?= obj_dir
LOG      ?= sim.log
FAIL_MSG := TB FAILED

SIM_BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

$(SIM_BIN): $(FILELIST) $(shell cat $(FILELIST))
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

test: $(SIM_BIN)
	@./$(SIM_BIN) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
	   echo "Simulation failed, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
